//--- verilog/riscv_defines.sv
`default_nettype none

package riscv_defines;

  // datapath width, fixed by the ISA
  localparam int xlen = 32;

  // shift amount only uses the low bits of operand b
  localparam int shamt_width = 5;

  // encoded widths of the enums below
  localparam int alu_op_width = 4;
  localparam int opc_width    = 7;
  localparam int kind_width   = 2;

  // alu operators, sixteen of them fill the 4-bit code
  typedef enum logic [alu_op_width-1:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slts,
    alu_sltu,
    alu_eq,
    alu_ne,
    alu_lts,
    alu_ges,
    alu_ltu,
    alu_geu
  } alu_op_e;

  // major opcodes of the supported rv32i classes
  typedef enum logic [opc_width-1:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_branch = 7'b1100011
  } opcode_e;

  // what the execute register does with the alu outputs
  typedef enum logic [kind_width-1:0] {
    kind_alu,
    kind_mem,
    kind_branch,
    kind_illegal
  } ex_kind_e;

endpackage

`default_nettype wire

//--- verilog/riscv_alu_if.sv
`default_nettype none

interface riscv_alu_if;

  // decoder side
  riscv_defines::alu_op_e        operator;
  logic [riscv_defines::xlen-1:0] operand_a;
  logic [riscv_defines::xlen-1:0] operand_b;
  riscv_defines::ex_kind_e       kind;
  logic                          valid;

  // alu side
  logic [riscv_defines::xlen-1:0] result;
  logic [riscv_defines::xlen-1:0] adder_result;
  logic                          comparison_result;

  modport decoder (output operator, operand_a, operand_b, kind, valid);
  modport alu (input operator, operand_a, operand_b,
               output result, adder_result, comparison_result);
  modport stage (input valid, kind, result, adder_result, comparison_result);

endinterface

`default_nettype wire

//--- verilog/riscv_alu_decoder.sv
`default_nettype none

module riscv_alu_decoder
(
  input  logic [riscv_defines::xlen-1:0] instr_i,
  input  logic [riscv_defines::xlen-1:0] rs1_data_i,
  input  logic [riscv_defines::xlen-1:0] rs2_data_i,
  input  logic                          valid_i,
  riscv_alu_if.decoder                  alu
);

  // instruction fields
  logic [riscv_defines::opc_width-1:0] opcode;
  logic [2:0]                          funct3;
  logic [6:0]                          funct7;
  logic                                funct7_zero;
  logic                                funct7_alt;
  logic                                is_op;

  // sign-extended immediates
  logic [riscv_defines::xlen-1:0]      imm_i;
  logic [riscv_defines::xlen-1:0]      imm_s;

  riscv_defines::ex_kind_e             class_kind;
  logic                                bad;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // funct7 of zero is the base op, 0x20 flips to sub or sra
  assign funct7_zero = (funct7 == 7'h00);
  assign funct7_alt  = (funct7 == 7'h20);
  assign is_op       = (opcode == riscv_defines::opc_op);

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  // operand a is always rs1
  assign alu.operand_a = rs1_data_i;
  assign alu.valid     = valid_i;
  assign alu.kind      = bad ? riscv_defines::kind_illegal : class_kind;

  // second operand mux
  always_comb
  begin
    case (opcode)
      riscv_defines::opc_op_imm,
      riscv_defines::opc_load:  alu.operand_b = imm_i;
      riscv_defines::opc_store: alu.operand_b = imm_s;
      default:                  alu.operand_b = rs2_data_i;
    endcase
  end

  // operator and class selection
  always_comb
  begin
    alu.operator = riscv_defines::alu_add;
    class_kind   = riscv_defines::kind_alu;
    bad          = 1'b0;

    case (opcode)
      riscv_defines::opc_op,
      riscv_defines::opc_op_imm:
      begin
        // register form requires a clean funct7, except sub and sra
        case (funct3)
          3'b000:
          begin
            if (is_op && funct7_alt)
              alu.operator = riscv_defines::alu_sub;
            else
              bad = is_op && !funct7_zero;
          end
          3'b001:
          begin
            alu.operator = riscv_defines::alu_sll;
            bad          = !funct7_zero;
          end
          3'b010:
          begin
            alu.operator = riscv_defines::alu_slts;
            bad          = is_op && !funct7_zero;
          end
          3'b011:
          begin
            alu.operator = riscv_defines::alu_sltu;
            bad          = is_op && !funct7_zero;
          end
          3'b100:
          begin
            alu.operator = riscv_defines::alu_xor;
            bad          = is_op && !funct7_zero;
          end
          // immediate shifts also carry funct7 in the top bits
          3'b101:
          begin
            alu.operator = funct7_alt ? riscv_defines::alu_sra : riscv_defines::alu_srl;
            bad          = !funct7_zero && !funct7_alt;
          end
          3'b110:
          begin
            alu.operator = riscv_defines::alu_or;
            bad          = is_op && !funct7_zero;
          end
          default:
          begin
            alu.operator = riscv_defines::alu_and;
            bad          = is_op && !funct7_zero;
          end
        endcase
      end

      // address is rs1 plus offset
      riscv_defines::opc_load,
      riscv_defines::opc_store:
      begin
        class_kind = riscv_defines::kind_mem;
      end

      riscv_defines::opc_branch:
      begin
        class_kind = riscv_defines::kind_branch;
        case (funct3)
          3'b000:  alu.operator = riscv_defines::alu_eq;
          3'b001:  alu.operator = riscv_defines::alu_ne;
          3'b100:  alu.operator = riscv_defines::alu_lts;
          3'b101:  alu.operator = riscv_defines::alu_ges;
          3'b110:  alu.operator = riscv_defines::alu_ltu;
          3'b111:  alu.operator = riscv_defines::alu_geu;
          // funct3 2 and 3 are reserved
          default: bad = 1'b1;
        endcase
      end

      default:
      begin
        bad = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/riscv_alu_simplified.sv
`default_nettype none

module riscv_alu_simplified
(
  input  logic     clk,
  input  logic     rst_n_i,
  riscv_alu_if.alu alu
);

  // mirror a word end for end
  function automatic logic [riscv_defines::xlen-1:0] bit_rev(
    input logic [riscv_defines::xlen-1:0] v
  );
    logic [riscv_defines::xlen-1:0] r;
    for (int k = 0; k < riscv_defines::xlen; k++)
    begin
      r[k] = v[riscv_defines::xlen-1-k];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////

  logic                         adder_negate;
  logic                         cmp_signed;
  logic                         ext_a;
  logic                         ext_b;
  logic [riscv_defines::xlen:0] adder_in_a;
  logic [riscv_defines::xlen:0] adder_in_b;
  logic [riscv_defines::xlen:0] adder_sum;

  // sub and every compare run through the adder as a minus b
  always_comb
  begin
    adder_negate = 1'b1;
    cmp_signed   = 1'b0;
    case (alu.operator)
      riscv_defines::alu_add,
      riscv_defines::alu_xor,
      riscv_defines::alu_or,
      riscv_defines::alu_and,
      riscv_defines::alu_sll,
      riscv_defines::alu_srl,
      riscv_defines::alu_sra:  adder_negate = 1'b0;
      riscv_defines::alu_slts,
      riscv_defines::alu_lts,
      riscv_defines::alu_ges:  cmp_signed = 1'b1;
      default:;
    endcase
  end

  // extra top bit gives a sign or zero extension to 33 bits
  assign ext_a = cmp_signed & alu.operand_a[riscv_defines::xlen-1];
  assign ext_b = cmp_signed & alu.operand_b[riscv_defines::xlen-1];

  assign adder_in_a = {ext_a, alu.operand_a};
  assign adder_in_b = adder_negate ? ~{ext_b, alu.operand_b} : {ext_b, alu.operand_b};

  // carry in completes the two's complement
  assign adder_sum = adder_in_a + adder_in_b + {{riscv_defines::xlen{1'b0}}, adder_negate};

  assign alu.adder_result = adder_sum[riscv_defines::xlen-1:0];

  ////////////////////////////////////////////////////////////
  // shifter
  ////////////////////////////////////////////////////////////

  logic                                  shift_left;
  logic                                  shift_arith;
  logic [riscv_defines::shamt_width-1:0] shift_amt;
  logic [riscv_defines::xlen-1:0]        shift_op_a;
  logic [2*riscv_defines::xlen-1:0]      shift_ext;
  logic [2*riscv_defines::xlen-1:0]      shift_wide;
  logic [riscv_defines::xlen-1:0]        shift_right;
  logic [riscv_defines::xlen-1:0]        shift_result;

  assign shift_left  = (alu.operator == riscv_defines::alu_sll);
  assign shift_arith = (alu.operator == riscv_defines::alu_sra);
  assign shift_amt   = alu.operand_b[riscv_defines::shamt_width-1:0];

  // left shift is a right shift of the reversed word
  assign shift_op_a = shift_left ? bit_rev(alu.operand_a) : alu.operand_a;

  // upper half holds the fill bits
  assign shift_ext = {{riscv_defines::xlen{shift_arith & shift_op_a[riscv_defines::xlen-1]}},
                      shift_op_a};

  assign shift_wide   = shift_ext >> shift_amt;
  assign shift_right  = shift_wide[riscv_defines::xlen-1:0];
  assign shift_result = shift_left ? bit_rev(shift_right) : shift_right;

  ////////////////////////////////////////////////////////////
  // comparator
  ////////////////////////////////////////////////////////////

  logic is_equal;
  logic is_greater;
  logic cmp_result;

  // zero difference means equal, sign of the 33-bit difference means less
  assign is_equal   = ~|adder_sum[riscv_defines::xlen-1:0];
  assign is_greater = ~adder_sum[riscv_defines::xlen] & ~is_equal;

  always_comb
  begin
    case (alu.operator)
      riscv_defines::alu_eq:   cmp_result = is_equal;
      riscv_defines::alu_ne:   cmp_result = ~is_equal;
      riscv_defines::alu_ges,
      riscv_defines::alu_geu:  cmp_result = is_greater | is_equal;
      riscv_defines::alu_lts,
      riscv_defines::alu_ltu,
      riscv_defines::alu_slts,
      riscv_defines::alu_sltu: cmp_result = ~(is_greater | is_equal);
      default:                 cmp_result = 1'b0;
    endcase
  end

  assign alu.comparison_result = cmp_result;

  ////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (alu.operator)
      riscv_defines::alu_and: alu.result = alu.operand_a & alu.operand_b;
      riscv_defines::alu_or:  alu.result = alu.operand_a | alu.operand_b;
      riscv_defines::alu_xor: alu.result = alu.operand_a ^ alu.operand_b;
      riscv_defines::alu_add,
      riscv_defines::alu_sub: alu.result = adder_sum[riscv_defines::xlen-1:0];
      riscv_defines::alu_sll,
      riscv_defines::alu_srl,
      riscv_defines::alu_sra: alu.result = shift_result;
      // compares return 0 or 1, zero extended
      default:                alu.result = {{(riscv_defines::xlen-1){1'b0}}, cmp_result};
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/riscv_ex_stage.sv
`default_nettype none

module riscv_ex_stage
(
  input  logic                          clk,
  input  logic                          rst_n_i,
  riscv_alu_if.stage                    alu,
  output logic                          valid_o,
  output logic [riscv_defines::xlen-1:0] result_o,
  output logic                          branch_taken_o,
  output logic                          illegal_o
);

  logic [riscv_defines::xlen-1:0] result_d;
  logic                          taken_d;
  logic                          illegal_d;

  logic                          valid_q;
  logic [riscv_defines::xlen-1:0] result_q;
  logic                          taken_q;
  logic                          illegal_q;

  // pick what goes out for this class
  always_comb
  begin
    case (alu.kind)
      riscv_defines::kind_alu: result_d = alu.result;
      riscv_defines::kind_mem: result_d = alu.adder_result;
      // branches and illegal ops show zero
      default:                 result_d = '0;
    endcase
  end

  assign taken_d   = alu.comparison_result && (alu.kind == riscv_defines::kind_branch);
  assign illegal_d = (alu.kind == riscv_defines::kind_illegal);

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q   <= 1'b0;
      result_q  <= '0;
      taken_q   <= 1'b0;
      illegal_q <= 1'b0;
    end
    else
    begin
      // strobe follows the input each cycle
      valid_q <= alu.valid;
      // data only moves on a valid cycle, otherwise it holds
      if (alu.valid)
      begin
        result_q  <= result_d;
        taken_q   <= taken_d;
        illegal_q <= illegal_d;
      end
    end
  end

  assign valid_o        = valid_q;
  assign result_o       = result_q;
  assign branch_taken_o = taken_q;
  assign illegal_o      = illegal_q;

endmodule

`default_nettype wire

//--- verilog/riscv_ex_top.sv
`default_nettype none

module riscv_ex_top
(
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  input  logic [riscv_defines::xlen-1:0] instr_i,
  input  logic [riscv_defines::xlen-1:0] rs1_data_i,
  input  logic [riscv_defines::xlen-1:0] rs2_data_i,
  output logic                          valid_o,
  output logic [riscv_defines::xlen-1:0] result_o,
  output logic                          branch_taken_o,
  output logic                          illegal_o
);

  // bundle between decode, alu and the output register
  riscv_alu_if alu_bus ();

  // decode and alu are combinational, the stage adds the one cycle
  riscv_alu_decoder decoder0 (
    .instr_i    (instr_i),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .valid_i    (valid_i),
    .alu        (alu_bus.decoder)
  );

  riscv_alu_simplified alu0 (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .alu     (alu_bus.alu)
  );

  riscv_ex_stage stage0 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .alu            (alu_bus.stage),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o),
    .illegal_o      (illegal_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_riscv_ex_top.sv
`default_nettype none

module tb_riscv_ex_top;

  timeunit 1ns;
  timeprecision 100ps;

  // stimulus then expected outputs
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] res;
    logic        taken;
    logic        ill;
  } row_t;

  logic        clk;
  logic        rst_n_i;
  logic        valid_i;
  logic [31:0] instr_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  logic        valid_o;
  logic [31:0] result_o;
  logic        branch_taken_o;
  logic        illegal_o;

  row_t directed[$];
  // rows in flight with the oldest first
  row_t expected[$];
  logic expect_valid;
  int   random_count = 200;
  int   cycles = 0;
  int   cycle_limit;
  int   errors = 0;
  int   checks = 0;

  riscv_ex_top dut0 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .instr_i        (instr_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o),
    .illegal_o      (illegal_o)
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // instruction encoders with rd=3 rs1=1 rs2=2
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {imm, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, 3'd2, imm[4:0], 7'(riscv_defines::opc_store)};
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic row_t predict(input logic [31:0] instr, input logic [31:0] rs1,
                                   input logic [31:0] rs2);
    row_t        r;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] b;
    logic [4:0]  sh;
    logic        alt;
    r.instr = instr;
    r.rs1   = rs1;
    r.rs2   = rs2;
    r.res   = '0;
    r.taken = 1'b0;
    r.ill   = 1'b0;
    opc     = instr[6:0];
    f3      = instr[14:12];
    f7      = instr[31:25];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    alt     = (f7 == 7'h20);
    case (opc)
      riscv_defines::opc_op,
      riscv_defines::opc_op_imm:
      begin
        b  = (opc == riscv_defines::opc_op) ? rs2 : imm_i;
        sh = b[4:0];
        // register form allows funct7 0, or 0x20 on sub and sra
        if (opc == riscv_defines::opc_op && f7 != 7'h00 && !(alt && (f3 == 3'd0 || f3 == 3'd5)))
          r.ill = 1'b1;
        // immediate shifts still carry funct7
        if (f3 == 3'd1 && f7 != 7'h00)
          r.ill = 1'b1;
        if (f3 == 3'd5 && f7 != 7'h00 && !alt)
          r.ill = 1'b1;
        case (f3)
          3'd0:    r.res = (opc == riscv_defines::opc_op && alt) ? rs1 - b : rs1 + b;
          3'd1:    r.res = rs1 << sh;
          3'd2:    r.res = {31'b0, $signed(rs1) < $signed(b)};
          3'd3:    r.res = {31'b0, rs1 < b};
          3'd4:    r.res = rs1 ^ b;
          3'd5:
          begin
            if (alt)
              r.res = $signed(rs1) >>> sh;
            else
              r.res = rs1 >> sh;
          end
          3'd6:    r.res = rs1 | b;
          default: r.res = rs1 & b;
        endcase
      end
      riscv_defines::opc_load:  r.res = rs1 + imm_i;
      riscv_defines::opc_store: r.res = rs1 + imm_s;
      riscv_defines::opc_branch:
      begin
        case (f3)
          3'd0:    r.taken = (rs1 == rs2);
          3'd1:    r.taken = (rs1 != rs2);
          3'd4:    r.taken = ($signed(rs1) < $signed(rs2));
          3'd5:    r.taken = ($signed(rs1) >= $signed(rs2));
          3'd6:    r.taken = (rs1 < rs2);
          3'd7:    r.taken = (rs1 >= rs2);
          default: r.ill = 1'b1;
        endcase
      end
      default: r.ill = 1'b1;
    endcase
    // illegal ops show nothing but the flag
    if (r.ill)
    begin
      r.res   = '0;
      r.taken = 1'b0;
    end
    return r;
  endfunction

  task automatic add_row(input logic [31:0] instr, input logic [31:0] rs1,
                         input logic [31:0] rs2, input logic [31:0] res,
                         input logic taken, input logic ill);
    directed.push_back({instr, rs1, rs2, res, taken, ill});
  endtask

  task automatic build_table();
    // arithmetic and logic with wrap-around
    add_row(enc_r(7'h00, 3'd0, riscv_defines::opc_op), 32'hffffffff, 32'h2, 32'h1, 1'b0, 1'b0);
    add_row(enc_r(7'h20, 3'd0, riscv_defines::opc_op), 32'h5, 32'h7, 32'hfffffffe, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd4, riscv_defines::opc_op), 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0,
            1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd6, riscv_defines::opc_op), 32'hf0f0f0f0, 32'h0f000f00, 32'hfff0fff0,
            1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd7, riscv_defines::opc_op), 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000,
            1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd2, riscv_defines::opc_op), 32'h80000000, 32'h1, 32'h1, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd3, riscv_defines::opc_op), 32'h80000000, 32'h1, 32'h0, 1'b0, 1'b0);
    add_row(enc_i(12'hfff, 3'd0, riscv_defines::opc_op_imm), 32'h10, 32'h0, 32'hf, 1'b0, 1'b0);
    add_row(enc_i(12'h0ff, 3'd4, riscv_defines::opc_op_imm), 32'hffff, 32'h0, 32'hff00, 1'b0, 1'b0);
    add_row(enc_i(12'hfff, 3'd2, riscv_defines::opc_op_imm), 32'h1, 32'h0, 32'h0, 1'b0, 1'b0);
    add_row(enc_i(12'hfff, 3'd3, riscv_defines::opc_op_imm), 32'h1, 32'h0, 32'h1, 1'b0, 1'b0);
    // shifts take only the low 5 bits of the amount
    add_row(enc_r(7'h00, 3'd1, riscv_defines::opc_op), 32'h1, 32'h24, 32'h10, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd5, riscv_defines::opc_op), 32'h80000000, 32'h3f, 32'h1, 1'b0, 1'b0);
    add_row(enc_r(7'h20, 3'd5, riscv_defines::opc_op), 32'h80000000, 32'h4, 32'hf8000000,
            1'b0, 1'b0);
    add_row(enc_i({7'h20, 5'd8}, 3'd5, riscv_defines::opc_op_imm), 32'hf0000000, 32'h0,
            32'hfff00000, 1'b0, 1'b0);
    add_row(enc_i({7'h00, 5'd3}, 3'd1, riscv_defines::opc_op_imm), 32'h1, 32'h0, 32'h8, 1'b0, 1'b0);
    // load and store addresses
    add_row(enc_i(12'hffc, 3'd2, riscv_defines::opc_load), 32'h1000, 32'h0, 32'hffc, 1'b0, 1'b0);
    add_row(enc_s(12'h010), 32'h2000, 32'h0, 32'h2010, 1'b0, 1'b0);
    add_row(enc_s(12'h800), 32'h0, 32'h0, 32'hfffff800, 1'b0, 1'b0);
    // branches
    add_row(enc_r(7'h00, 3'd0, riscv_defines::opc_branch), 32'h5, 32'h5, 32'h0, 1'b1, 1'b0);
    add_row(enc_r(7'h00, 3'd1, riscv_defines::opc_branch), 32'h5, 32'h5, 32'h0, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd4, riscv_defines::opc_branch), 32'hffffffff, 32'h1, 32'h0, 1'b1, 1'b0);
    add_row(enc_r(7'h00, 3'd5, riscv_defines::opc_branch), 32'hffffffff, 32'h1, 32'h0, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd6, riscv_defines::opc_branch), 32'hffffffff, 32'h1, 32'h0, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 3'd7, riscv_defines::opc_branch), 32'hffffffff, 32'h1, 32'h0, 1'b1, 1'b0);
    add_row(enc_r(7'h00, 3'd5, riscv_defines::opc_branch), 32'h7, 32'h7, 32'h0, 1'b1, 1'b0);
    // illegal encodings
    add_row(enc_r(7'h00, 3'd0, 7'h7f), 32'h1, 32'h2, 32'h0, 1'b0, 1'b1);
    add_row(enc_r(7'h00, 3'd2, riscv_defines::opc_branch), 32'h1, 32'h1, 32'h0, 1'b0, 1'b1);
    add_row(enc_r(7'h01, 3'd0, riscv_defines::opc_op), 32'h3, 32'h4, 32'h0, 1'b0, 1'b1);
  endtask

  // legal instruction of a random class
  task automatic make_random(output row_t row);
    logic [31:0] bits;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int unsigned pick;
    bits = $urandom;
    a    = $urandom;
    b    = $urandom;
    f3   = bits[14:12];
    f7   = bits[31:25];
    pick = $urandom_range(4, 0);
    case (pick)
      0:
      begin
        f7        = ((f3 == 3'd0 || f3 == 3'd5) && bits[30]) ? 7'h20 : 7'h00;
        bits[6:0] = riscv_defines::opc_op;
      end
      1:
      begin
        if (f3 == 3'd1)
          f7 = 7'h00;
        else if (f3 == 3'd5)
          f7 = bits[30] ? 7'h20 : 7'h00;
        bits[6:0] = riscv_defines::opc_op_imm;
      end
      2: bits[6:0] = riscv_defines::opc_load;
      3: bits[6:0] = riscv_defines::opc_store;
      default:
      begin
        // 2 and 3 fold onto beq and bne
        if (f3[2:1] == 2'b01)
          f3[1] = 1'b0;
        bits[6:0] = riscv_defines::opc_branch;
      end
    endcase
    bits[14:12] = f3;
    bits[31:25] = f7;
    // equal operands now and then for eq and ge
    if ($urandom_range(3, 0) == 0)
      b = a;
    row = predict(bits, a, b);
  endtask

  task automatic issue(input row_t row);
    @(posedge clk);
    valid_i    <= 1'b1;
    instr_i    <= row.instr;
    rs1_data_i <= row.rs1;
    rs2_data_i <= row.rs2;
    expected.push_back(row);
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checking and timeout
  ////////////////////////////////////////////////////////////

  // valid_o follows valid_i one edge later
  always @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      expect_valid <= 1'b0;
    else
      expect_valid <= valid_i;
  end

  // outputs are stable at the falling edge
  always @(negedge clk)
  begin
    row_t exp_row;
    if (rst_n_i)
    begin
      compare_value("valid_o", {31'b0, expect_valid}, {31'b0, valid_o});
      if (valid_o === 1'b1)
      begin
        if (expected.size() == 0)
        begin
          errors++;
          $display("Error at %0t ns: valid_o high with no instruction in flight", $time);
        end
        else
        begin
          exp_row = expected.pop_front();
          compare_value("result_o", exp_row.res, result_o);
          compare_value("branch_taken_o", {31'b0, exp_row.taken}, {31'b0, branch_taken_o});
          compare_value("illegal_o", {31'b0, exp_row.ill}, {31'b0, illegal_o});
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout reached after %0d cycles, %0d results still missing",
               cycles, expected.size());
      $display("Result: FAILED");
      $finish;
    end
  end

  initial
  begin
    row_t        rnd_row;
    int unsigned seed_val;
    clk        = 1'b0;
    rst_n_i    = 1'b0;
    valid_i    = 1'b0;
    instr_i    = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    // seed the generator once
    seed_val    = $urandom(32'h639bc8a3);
    build_table();
    cycle_limit = 2 * (directed.size() + random_count) + 20;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    // idle outputs after reset
    @(posedge clk);
    @(negedge clk);
    compare_value("valid_o", 32'h0, {31'b0, valid_o});
    compare_value("result_o", 32'h0, result_o);
    compare_value("branch_taken_o", 32'h0, {31'b0, branch_taken_o});
    compare_value("illegal_o", 32'h0, {31'b0, illegal_o});
    foreach (directed[i])
    begin
      issue(directed[i]);
    end
    // one gap so valid_o must drop
    @(posedge clk);
    valid_i <= 1'b0;
    for (int i = 0; i < random_count; i++)
    begin
      make_random(rnd_row);
      issue(rnd_row);
    end
    @(posedge clk);
    valid_i <= 1'b0;
    while (expected.size() != 0)
    begin
      @(negedge clk);
    end
    // last falling-edge checks are done before the summary
    @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/riscv_defines.sv
verilog/riscv_alu_if.sv
verilog/riscv_alu_decoder.sv
verilog/riscv_alu_simplified.sv
verilog/riscv_ex_stage.sv
verilog/riscv_ex_top.sv
dv/tb_riscv_ex_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_riscv_ex_top
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
